// ==== logic/vdec_pkg.sv ====
// --------------------
// shared sizes, encodings and bundles for the vector decode stage
// funct6 codes follow the OPIVV/OPIVX/OPIVI map; vslide1up and
// vslide1down use local codes since only OPI funct3 values decode
// elements are always stored 32 bits wide; sew only tags the bundle
// --------------------
package vdec_pkg;

  localparam int NUM_VREGS      = 32;
  localparam int ELEMS_PER_REG  = 8;
  localparam int ELEM_WIDTH     = 32;
  localparam int VREG_IDX_WIDTH = 5;
  localparam int OFFSET_WIDTH   = 32;
  localparam int ELEM_IDX_WIDTH = $clog2(ELEMS_PER_REG);
  localparam logic [6:0] OPV_OPCODE = 7'b1010111;

  typedef logic [VREG_IDX_WIDTH-1:0] vreg_idx_t;
  typedef logic [OFFSET_WIDTH-1:0]   offset_t;
  typedef logic [ELEM_WIDTH-1:0]     elem_t;

  typedef enum logic [1:0] {SEW8 = 2'b00, SEW16 = 2'b01, SEW32 = 2'b10} sew_t;

  typedef enum logic [2:0] {OPIVV = 3'b000, OPIVI = 3'b011, OPIVX = 3'b100} vfunct3_t;

  // values are the funct6 field
  typedef enum logic [5:0] {
    VADD        = 6'b000000,
    VSUB        = 6'b000010,
    VRGATHER    = 6'b001100,
    VSLIDEUP    = 6'b001110,
    VSLIDEDOWN  = 6'b001111,
    VSLIDE1UP   = 6'b011110,
    VSLIDE1DOWN = 6'b011111,
    VMV         = 6'b010111,
    VWADD       = 6'b110001
  } vop_t;

  typedef enum logic {VS1_SRC_NORMAL, VS1_SRC_ZERO} vs1_src_t;

  typedef enum logic [2:0] {
    VS2_SRC_NORMAL, VS2_SRC_IDX_PLUS_RS1, VS2_SRC_IDX_PLUS_UIMM, VS2_SRC_IDX_PLUS_1,
    VS2_SRC_VS1, VS2_SRC_RS1, VS2_SRC_UIMM, VS2_SRC_ZERO
  } vs2_src_t;

  typedef enum logic [2:0] {
    VD_SRC_NORMAL, VD_SRC_ZERO, VD_SRC_IDX_PLUS_RS1, VD_SRC_IDX_PLUS_UIMM, VD_SRC_IDX_PLUS_1
  } vd_src_t;

  typedef struct packed {
    vop_t      op;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    vreg_idx_t vd;
    offset_t   imm;
    logic      is_signed;
    logic      masked;
    logic      vd_widen;
    vs1_src_t  vs1_src;
    vs2_src_t  vs2_src;
    vd_src_t   vd_src;
    sew_t      sew;
  } vctrl_t;

  // lane0 sits in the low half
  typedef struct packed {
    elem_t lane1;
    elem_t lane0;
  } elem_pair_t;

  typedef struct packed {
    offset_t lane1;
    offset_t lane0;
  } offset_pair_t;

  typedef struct packed {
    vop_t         op;
    vreg_idx_t    vd;
    elem_pair_t   vs1_data;
    elem_pair_t   vs2_data;
    elem_pair_t   vs3_data;
    offset_pair_t woffset;
    offset_t      imm;
    offset_t      xs1;
    logic         mask0;
    logic         mask1;
    logic         wen0;
    logic         wen1;
    sew_t         eew;
    sew_t         sew;
    offset_t      vl;
  } de_bundle_t;

endpackage

// ==== logic/vinstr_decoder.sv ====
// --------------------
// accepts one OP-V instruction while idle and not stalled
// the control word, xs1 and vl stay latched until the next accept
// start or illegal pulse one cycle after the accepting edge
// --------------------
module vinstr_decoder (
  input  logic              CLK,
  input  logic              nRST,
  input  logic [31:0]       instr,
  input  logic              in_valid,
  input  logic              busy,
  input  logic              stall,
  input  logic              flush,
  input  vdec_pkg::offset_t vl,
  input  vdec_pkg::offset_t xs1,
  input  vdec_pkg::sew_t    vtype_sew,
  output vdec_pkg::vctrl_t  ctrl,
  output vdec_pkg::offset_t ctrl_xs1,
  output vdec_pkg::offset_t ctrl_vl,
  output logic              start,
  output logic              illegal
);
  import vdec_pkg::*;

  logic [5:0] funct6;
  logic [2:0] funct3;
  logic [6:0] opcode;
  logic [4:0] imm5;
  logic       accept;
  logic       legal;
  vctrl_t     next_ctrl;

  assign funct6 = instr[31:26];
  assign funct3 = instr[14:12];
  assign opcode = instr[6:0];
  assign imm5   = instr[19:15];

  // start still pending counts as busy, the sequencer has not seen it yet
  assign accept = in_valid && !busy && !start && !stall && !flush;

  always_comb begin
    next_ctrl          = '0;
    next_ctrl.op       = vop_t'(funct6);
    next_ctrl.vs1      = instr[19:15];
    next_ctrl.vs2      = instr[24:20];
    next_ctrl.vd       = instr[11:7];
    next_ctrl.masked   = ~instr[25];
    next_ctrl.sew      = vtype_sew;
    next_ctrl.vd_widen = (funct6 == VWADD);
    next_ctrl.vs1_src  = (funct3 == OPIVV) ? VS1_SRC_NORMAL : VS1_SRC_ZERO;
    next_ctrl.vs2_src  = VS2_SRC_NORMAL;
    next_ctrl.vd_src   = VD_SRC_NORMAL;
    legal = (opcode == OPV_OPCODE) && (funct3 inside {OPIVV, OPIVX, OPIVI});
    case (funct6)
      VADD, VSUB, VMV, VWADD: next_ctrl.is_signed = 1'b1;
      VSLIDEUP: begin
        legal = legal && (funct3 != OPIVV);
        next_ctrl.vd_src = (funct3 == OPIVX) ? VD_SRC_IDX_PLUS_RS1 : VD_SRC_IDX_PLUS_UIMM;
      end
      VSLIDEDOWN: begin
        legal = legal && (funct3 != OPIVV);
        next_ctrl.vs2_src = (funct3 == OPIVX) ? VS2_SRC_IDX_PLUS_RS1 : VS2_SRC_IDX_PLUS_UIMM;
      end
      VSLIDE1UP: begin
        legal = legal && (funct3 == OPIVX);
        next_ctrl.vd_src = VD_SRC_IDX_PLUS_1;
      end
      VSLIDE1DOWN: begin
        legal = legal && (funct3 == OPIVX);
        next_ctrl.vs2_src = VS2_SRC_IDX_PLUS_1;
      end
      VRGATHER: begin
        case (funct3)
          OPIVV:   next_ctrl.vs2_src = VS2_SRC_VS1;
          OPIVX:   next_ctrl.vs2_src = VS2_SRC_RS1;
          default: next_ctrl.vs2_src = VS2_SRC_UIMM;
        endcase
      end
      default: legal = 1'b0;
    endcase
    // sign extension only for the arithmetic forms
    if (next_ctrl.is_signed) begin
      next_ctrl.imm = {{(OFFSET_WIDTH-5){imm5[4]}}, imm5};
    end else begin
      next_ctrl.imm = {{(OFFSET_WIDTH-5){1'b0}}, imm5};
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ctrl     <= '0;
      ctrl_xs1 <= '0;
      ctrl_vl  <= '0;
      start    <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      start   <= accept && legal;
      illegal <= accept && !legal;
      if (accept && legal) begin
        ctrl     <= next_ctrl;
        ctrl_xs1 <= xs1;
        ctrl_vl  <= vl;
      end
    end
  end

endmodule

// ==== logic/element_sequencer.sv ====
// --------------------
// walks the element index in steps of 2 while busy
// start arms busy even under stall; a vl of 0 never sets busy
// busy drops on the edge that issues the last pair
// --------------------
module element_sequencer (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              start,
  input  logic              stall,
  input  logic              flush,
  input  vdec_pkg::offset_t vl,
  output logic              busy,
  output logic              pair_valid,
  output vdec_pkg::offset_t elem_idx
);
  import vdec_pkg::*;

  offset_t idx;
  offset_t next_idx;
  logic    last_pair;

  assign next_idx  = idx + offset_t'(2);
  assign last_pair = (next_idx >= vl);

  // a pair is issued every cycle that busy is held
  assign pair_valid = busy;
  assign elem_idx   = idx;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (flush) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (!busy) begin
      if (start && (vl != '0)) begin
        busy <= 1'b1;
      end
      idx <= '0;
    end else if (!stall) begin
      if (last_pair) begin
        busy <= 1'b0;
        idx  <= '0;
      end else begin
        idx <= next_idx;
      end
    end
  end

endmodule

// ==== logic/offset_gen.sv ====
// --------------------
// combinational element offsets for both lanes
// offsets are not clipped, the register file zeroes reads past the end
// --------------------
module offset_gen (
  input  vdec_pkg::vctrl_t       ctrl,
  input  vdec_pkg::offset_t      elem_idx,
  input  vdec_pkg::offset_t      xs1,
  input  vdec_pkg::elem_pair_t   vs1_data,
  output vdec_pkg::offset_pair_t vs1_off,
  output vdec_pkg::offset_pair_t vs2_off,
  output vdec_pkg::offset_pair_t vd_off,
  output vdec_pkg::sew_t         eew
);
  import vdec_pkg::*;

  // lane1 sits step elements past lane0
  function automatic offset_pair_t make_pair(input offset_t base, input offset_t step);
    offset_pair_t p;
    p.lane0 = base;
    p.lane1 = base + step;
    return p;
  endfunction

  always_comb begin
    case (ctrl.vs1_src)
      VS1_SRC_NORMAL: vs1_off = make_pair(elem_idx, 1);
      default:        vs1_off = '0;
    endcase
  end

  always_comb begin
    case (ctrl.vs2_src)
      VS2_SRC_NORMAL:        vs2_off = make_pair(elem_idx, 1);
      VS2_SRC_IDX_PLUS_RS1:  vs2_off = make_pair(elem_idx + xs1, 1);
      VS2_SRC_IDX_PLUS_UIMM: vs2_off = make_pair(elem_idx + ctrl.imm, 1);
      VS2_SRC_IDX_PLUS_1:    vs2_off = make_pair(elem_idx + offset_t'(1), 1);
      // gather by index held in vs1, one per lane
      VS2_SRC_VS1: begin
        vs2_off.lane0 = vs1_data.lane0;
        vs2_off.lane1 = vs1_data.lane1;
      end
      VS2_SRC_RS1:  vs2_off = make_pair(xs1, 0);
      VS2_SRC_UIMM: vs2_off = make_pair(ctrl.imm, 0);
      default:      vs2_off = '0;
    endcase
  end

  always_comb begin
    case (ctrl.vd_src)
      VD_SRC_NORMAL:        vd_off = make_pair(elem_idx, 1);
      VD_SRC_IDX_PLUS_RS1:  vd_off = make_pair(elem_idx + xs1, 1);
      VD_SRC_IDX_PLUS_UIMM: vd_off = make_pair(elem_idx + ctrl.imm, 1);
      VD_SRC_IDX_PLUS_1:    vd_off = make_pair(elem_idx + offset_t'(1), 1);
      default:              vd_off = '0;
    endcase
  end

  // widening doubles the destination width, capped at 32
  always_comb begin
    eew = ctrl.sew;
    if (ctrl.vd_widen) begin
      eew = (ctrl.sew == SEW8) ? SEW16 : SEW32;
    end
  end

endmodule

// ==== logic/vector_regfile.sv ====
// --------------------
// 32 registers of 8 elements of 32 bits
// reads are combinational; offsets of 8 and above read as 0
// out-of-range writes are dropped
// --------------------
module vector_regfile (
  input  logic                   CLK,
  input  logic                   nRST,
  input  vdec_pkg::vreg_idx_t    vs1,
  input  vdec_pkg::vreg_idx_t    vs2,
  input  vdec_pkg::vreg_idx_t    vd,
  input  vdec_pkg::offset_pair_t vs1_off,
  input  vdec_pkg::offset_pair_t vs2_off,
  input  vdec_pkg::offset_pair_t vd_off,
  output vdec_pkg::elem_pair_t   vs1_data,
  output vdec_pkg::elem_pair_t   vs2_data,
  output vdec_pkg::elem_pair_t   vs3_data,
  output logic                   mask0,
  output logic                   mask1,
  input  logic                   wb_en,
  input  vdec_pkg::vreg_idx_t    wb_vreg,
  input  vdec_pkg::offset_t      wb_offset,
  input  vdec_pkg::elem_t        wb_data
);
  import vdec_pkg::*;

  elem_t regs [NUM_VREGS][ELEMS_PER_REG];
  elem_t v0_lane0;
  elem_t v0_lane1;

  function automatic elem_t read_elem(input vreg_idx_t r, input offset_t off);
    elem_t val;
    val = '0;
    if (off < ELEMS_PER_REG) begin
      val = regs[r][off[ELEM_IDX_WIDTH-1:0]];
    end
    return val;
  endfunction

  always_comb begin
    vs1_data.lane0 = read_elem(vs1, vs1_off.lane0);
    vs1_data.lane1 = read_elem(vs1, vs1_off.lane1);
  end

  // gather offsets come from the vs1 read above
  always_comb begin
    vs2_data.lane0 = read_elem(vs2, vs2_off.lane0);
    vs2_data.lane1 = read_elem(vs2, vs2_off.lane1);
  end

  always_comb begin
    vs3_data.lane0 = read_elem(vd, vd_off.lane0);
    vs3_data.lane1 = read_elem(vd, vd_off.lane1);
  end

  // mask bits follow the destination element
  always_comb begin
    v0_lane0 = read_elem('0, vd_off.lane0);
    v0_lane1 = read_elem('0, vd_off.lane1);
    mask0    = v0_lane0[0];
    mask1    = v0_lane1[0];
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int r = 0; r < NUM_VREGS; r++) begin
        for (int e = 0; e < ELEMS_PER_REG; e++) begin
          regs[r][e] <= '0;
        end
      end
    end else if (wb_en && (wb_offset < ELEMS_PER_REG)) begin
      regs[wb_vreg][wb_offset[ELEM_IDX_WIDTH-1:0]] <= wb_data;
    end
  end

endmodule

// ==== logic/decode_execute_reg.sv ====
// --------------------
// bundle register toward execute
// flush wins over stall; stall holds de_valid and the bundle
// --------------------
module decode_execute_reg (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 stall,
  input  logic                 flush,
  input  logic                 pair_valid,
  input  vdec_pkg::de_bundle_t next_bundle,
  output logic                 de_valid,
  output vdec_pkg::de_bundle_t de_bundle
);
  import vdec_pkg::*;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      de_valid  <= 1'b0;
      de_bundle <= '0;
    end else if (flush) begin
      de_valid  <= 1'b0;
      de_bundle <= '0;
    end else if (!stall) begin
      de_valid <= pair_valid;
      // idle cycles leave a zero bundle behind
      if (pair_valid) begin
        de_bundle <= next_bundle;
      end else begin
        de_bundle <= '0;
      end
    end
  end

endmodule

// ==== logic/vector_decode_top.sv ====
// --------------------
// vector decode stage: decoder, sequencer, offsets, register read, bundle
// first bundle shows 2 edges after acceptance, one per cycle after that
// the wb_* port writes the register file directly at the clock edge
// --------------------
module vector_decode_top (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 in_valid,
  input  logic [31:0]          instr,
  input  vdec_pkg::offset_t    vl,
  input  vdec_pkg::sew_t       vtype_sew,
  input  vdec_pkg::offset_t    xs1,
  input  logic                 stall,
  input  logic                 flush,
  input  logic                 wb_en,
  input  vdec_pkg::vreg_idx_t  wb_vreg,
  input  vdec_pkg::offset_t    wb_offset,
  input  vdec_pkg::elem_t      wb_data,
  output logic                 de_valid,
  output vdec_pkg::de_bundle_t de_bundle,
  output logic                 busy,
  output logic                 illegal
);
  import vdec_pkg::*;

  vctrl_t       ctrl;
  offset_t      ctrl_xs1;
  offset_t      ctrl_vl;
  logic         start;
  logic         pair_valid;
  offset_t      elem_idx;
  offset_pair_t vs1_off;
  offset_pair_t vs2_off;
  offset_pair_t vd_off;
  sew_t         eew;
  elem_pair_t   vs1_data;
  elem_pair_t   vs2_data;
  elem_pair_t   vs3_data;
  logic         rf_mask0;
  logic         rf_mask1;
  de_bundle_t   next_bundle;

  vinstr_decoder u_decoder (
    .CLK, .nRST, .instr, .in_valid, .busy, .stall, .flush, .vl, .xs1, .vtype_sew,
    .ctrl, .ctrl_xs1, .ctrl_vl, .start, .illegal
  );

  element_sequencer u_sequencer (
    .CLK, .nRST, .start, .stall, .flush, .vl(ctrl_vl), .busy, .pair_valid, .elem_idx
  );

  offset_gen u_offsets (
    .ctrl, .elem_idx, .xs1(ctrl_xs1), .vs1_data, .vs1_off, .vs2_off, .vd_off, .eew
  );

  vector_regfile u_regfile (
    .CLK, .nRST, .vs1(ctrl.vs1), .vs2(ctrl.vs2), .vd(ctrl.vd),
    .vs1_off, .vs2_off, .vd_off, .vs1_data, .vs2_data, .vs3_data,
    .mask0(rf_mask0), .mask1(rf_mask1), .wb_en, .wb_vreg, .wb_offset, .wb_data
  );

  always_comb begin
    next_bundle          = '0;
    next_bundle.op       = ctrl.op;
    next_bundle.vd       = ctrl.vd;
    next_bundle.vs1_data = vs1_data;
    next_bundle.vs2_data = vs2_data;
    next_bundle.vs3_data = vs3_data;
    next_bundle.woffset  = vd_off;
    next_bundle.imm      = ctrl.imm;
    next_bundle.xs1      = ctrl_xs1;
    // unmasked ops write every element
    next_bundle.mask0    = ctrl.masked ? rf_mask0 : 1'b1;
    next_bundle.mask1    = ctrl.masked ? rf_mask1 : 1'b1;
    next_bundle.wen0     = pair_valid;
    // odd vl leaves lane1 of the last pair idle
    next_bundle.wen1     = pair_valid && ((elem_idx + offset_t'(1)) < ctrl_vl);
    next_bundle.eew      = eew;
    next_bundle.sew      = ctrl.sew;
    next_bundle.vl       = ctrl_vl;
  end

  decode_execute_reg u_de_reg (
    .CLK, .nRST, .stall, .flush, .pair_valid, .next_bundle, .de_valid, .de_bundle
  );

endmodule

// ==== testbench/vdec_checks.svh ====
// --------------------
// typed compare and wait tasks for the decode testbench
// included inside the testbench module, uses its signals
// the first mismatch or timeout ends the run
// --------------------
`ifndef VDEC_CHECKS_SVH
`define VDEC_CHECKS_SVH

  task automatic stop_run(input string why);
    fail_count++;
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_bundle(input de_bundle_t got, input de_bundle_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s bundle mismatch", $time, what);
      $display("  expected %h", exp);
      $display("  got      %h", got);
      stop_run("bundle compare failed");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s expected %b got %b", $time, what, exp, got);
      stop_run("flag compare failed");
    end
  endtask

  task automatic check_sew(input sew_t got, input sew_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s expected %s got %s", $time, what, exp.name(), got.name());
      stop_run("width compare failed");
    end
  endtask

  // returns at the first falling edge that sees de_valid high
  task automatic wait_de_valid(input int limit);
    int n;
    n = 0;
    while (de_valid !== 1'b1) begin
      if (n >= limit) begin
        stop_run("timed out waiting for de_valid");
      end
      @(negedge CLK);
      n++;
    end
  endtask

  task automatic wait_illegal(input int limit);
    int n;
    n = 0;
    while (illegal !== 1'b1) begin
      if (n >= limit) begin
        stop_run("timed out waiting for the illegal pulse");
      end
      @(negedge CLK);
      n++;
    end
  endtask

`endif

// ==== testbench/vector_decode_tb.sv ====
// --------------------
// testbench for the vector decode stage
// stimulus and expected bundles come from testbench/decode_cases.txt
// register file is filled with (vreg << 8) | offset before the cases
// inputs change and outputs are sampled on falling edges
// --------------------
module vector_decode_tb;
  import vdec_pkg::*;

  logic       CLK;
  logic       nRST;
  logic       in_valid;
  logic [31:0] instr;
  offset_t    vl;
  sew_t       vtype_sew;
  offset_t    xs1;
  logic       stall;
  logic       flush;
  logic       wb_en;
  vreg_idx_t  wb_vreg;
  offset_t    wb_offset;
  elem_t      wb_data;
  logic       de_valid;
  de_bundle_t de_bundle;
  logic       busy;
  logic       illegal;
  int         fail_count;
  int         fd;

  `include "vdec_checks.svh"

  vector_decode_top UUT (
    .CLK, .nRST, .in_valid, .instr, .vl, .vtype_sew, .xs1, .stall, .flush,
    .wb_en, .wb_vreg, .wb_offset, .wb_data, .de_valid, .de_bundle, .busy, .illegal
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic write_elem(input int r, input int off, input elem_t data);
    @(negedge CLK);
    wb_en     = 1'b1;
    wb_vreg   = vreg_idx_t'(r);
    wb_offset = offset_t'(off);
    wb_data   = data;
    @(negedge CLK);
    wb_en = 1'b0;
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge CLK);
      check_flag(de_valid, 1'b0, "de_valid while idle");
      check_flag(busy, 1'b0, "busy while idle");
    end
  endtask

  // runs one instruction against the E lines that follow it
  task automatic run_case(input logic [31:0] ins, input offset_t n_vl, input sew_t s,
                          input offset_t x, input offset_t im, input logic [31:0] pat);
    de_bundle_t  exp_q[$];
    de_bundle_t  b;
    de_bundle_t  held;
    logic        held_valid;
    logic        prev_stall;
    logic [31:0] f [12];
    string       tag;
    int          npairs;
    int          k;
    int          c;
    int          first_at;
    npairs = (int'(n_vl) + 1) / 2;
    for (int i = 0; i < npairs; i++) begin
      void'($fscanf(fd, "%s", tag));
      if (tag != "E") begin
        stop_run("case file is missing an expected bundle line");
      end
      void'($fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                    f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]));
      b                = '0;
      b.op             = vop_t'(ins[31:26]);
      b.vd             = ins[11:7];
      b.vs1_data.lane0 = f[0];
      b.vs1_data.lane1 = f[1];
      b.vs2_data.lane0 = f[2];
      b.vs2_data.lane1 = f[3];
      b.vs3_data.lane0 = f[4];
      b.vs3_data.lane1 = f[5];
      b.woffset.lane0  = f[6];
      b.woffset.lane1  = f[7];
      b.imm            = im;
      b.xs1            = x;
      b.mask0          = f[8][0];
      b.mask1          = f[9][0];
      b.wen0           = 1'b1;
      b.wen1           = f[10][0];
      b.eew            = sew_t'(f[11][1:0]);
      b.sew            = s;
      b.vl             = n_vl;
      exp_q.push_back(b);
    end
    @(negedge CLK);
    instr      = ins;
    vl         = n_vl;
    vtype_sew  = s;
    xs1        = x;
    in_valid   = 1'b1;
    stall      = 1'b0;
    k          = 0;
    c          = 0;
    first_at   = -1;
    prev_stall = 1'b0;
    held       = '0;
    held_valid = 1'b0;
    while (k < npairs) begin
      if (c >= 40) begin
        stop_run("timed out waiting for the bundles of a case");
      end
      @(negedge CLK);
      if (prev_stall) begin
        check_flag(de_valid, held_valid, "de_valid under stall");
        check_bundle(de_bundle, held, "held under stall");
      end else if (de_valid) begin
        check_flag(busy, (k != npairs - 1), "busy at bundle");
        check_sew(de_bundle.eew, exp_q[k].eew, "eew");
        check_bundle(de_bundle, exp_q[k], "issued pair");
        if (first_at < 0) begin
          first_at = c;
        end
        k++;
      end
      held       = de_bundle;
      held_valid = de_valid;
      // a second instruction while busy must be ignored
      in_valid   = (c == 1);
      instr      = (c == 1) ? 32'h0A208457 : ins;
      stall      = (c < 32) ? pat[c[4:0]] : 1'b0;
      prev_stall = stall;
      c++;
    end
    stall    = 1'b0;
    in_valid = 1'b0;
    if (pat == '0) begin
      check_flag(first_at == 2, 1'b1, "first bundle two edges after accept");
    end
    check_idle(3);
  endtask

  task automatic run_flush(input logic [31:0] ins, input offset_t n_vl, input sew_t s,
                           input offset_t x);
    @(negedge CLK);
    instr     = ins;
    vl        = n_vl;
    vtype_sew = s;
    xs1       = x;
    in_valid  = 1'b1;
    @(negedge CLK);
    in_valid = 1'b0;
    wait_de_valid(10);
    flush = 1'b1;
    @(negedge CLK);
    check_flag(de_valid, 1'b0, "de_valid after flush");
    check_flag(busy, 1'b0, "busy after flush");
    flush = 1'b0;
    check_idle(3);
  endtask

  task automatic run_illegal(input logic [31:0] ins);
    @(negedge CLK);
    instr    = ins;
    in_valid = 1'b1;
    @(negedge CLK);
    in_valid = 1'b0;
    wait_illegal(4);
    @(negedge CLK);
    check_flag(illegal, 1'b0, "illegal is one cycle");
    check_idle(3);
  endtask

  initial begin
    string       tag;
    logic [31:0] a;
    logic [31:0] v;
    logic [31:0] s;
    logic [31:0] x;
    logic [31:0] im;
    logic [31:0] pat;
    int          ch;
    fail_count = 0;
    nRST       = 1'b0;
    in_valid   = 1'b0;
    instr      = '0;
    vl         = '0;
    vtype_sew  = SEW32;
    xs1        = '0;
    stall      = 1'b0;
    flush      = 1'b0;
    wb_en      = 1'b0;
    wb_vreg    = '0;
    wb_offset  = '0;
    wb_data    = '0;
    repeat (5) @(negedge CLK);
    nRST = 1'b1;
    check_flag(de_valid, 1'b0, "de_valid after reset");
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(illegal, 1'b0, "illegal after reset");
    check_bundle(de_bundle, '0, "reset");
    for (int r = 0; r < NUM_VREGS; r++) begin
      for (int e = 0; e < ELEMS_PER_REG; e++) begin
        write_elem(r, e, elem_t'((r << 8) | e));
      end
    end
    fd = $fopen("testbench/decode_cases.txt", "r");
    if (fd == 0) begin
      stop_run("could not open the case file");
    end
    while (!$feof(fd)) begin
      if ($fscanf(fd, "%s", tag) == 1) begin
        if (tag == "#") begin
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else if (tag == "W") begin
          void'($fscanf(fd, "%h %h %h", a, v, s));
          write_elem(int'(a), int'(v), s);
        end else if (tag == "C") begin
          void'($fscanf(fd, "%h %h %h %h %h %h", a, v, s, x, im, pat));
          run_case(a, v, sew_t'(s[1:0]), x, im, pat);
        end else if (tag == "F") begin
          void'($fscanf(fd, "%h %h %h %h", a, v, s, x));
          run_flush(a, v, sew_t'(s[1:0]), x);
        end else if (tag == "I") begin
          void'($fscanf(fd, "%h", a));
          run_illegal(a);
        end else begin
          stop_run("unknown line in the case file");
        end
      end
    end
    $fclose(fd);
    if (fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== testbench/decode_cases.txt ====
# W vreg off data | C instr vl sew xs1 imm stall_bits, then one E line per pair | F instr vl sew xs1 | I instr
# E vs1_l0 vs1_l1 vs2_l0 vs2_l1 vs3_l0 vs3_l1 woff_l0 woff_l1 mask0 mask1 wen1 eew (all hex)
W 04 0 00000003
W 04 1 00000007
W 04 2 00000009
W 04 3 00000000
W 00 2 00000001
C 02208457 5 2 0 1 0
E 100 101 200 201 800 801 0 1 1 1 1 2
E 102 103 202 203 802 803 2 3 1 1 1 2
E 104 105 204 205 804 805 4 5 1 1 0 2
C 02208457 5 2 0 1 2A
E 100 101 200 201 800 801 0 1 1 1 1 2
E 102 103 202 203 802 803 2 3 1 1 1 2
E 104 105 204 205 804 805 4 5 1 1 0 2
C 3A22C4D7 4 2 2 5 0
E 500 500 200 201 902 903 2 3 1 1 1 2
E 500 500 202 203 904 905 4 5 1 1 1 2
C 3E333557 4 1 0 6 0
E 600 600 306 307 A00 A01 0 1 1 1 1 1
E 600 600 0 0 A02 A03 2 3 1 1 1 1
C 7E1045D7 2 2 55 0 0
E 0 0 101 102 B00 B01 0 1 1 1 1 2
C 32220657 4 2 0 4 0
E 3 7 203 207 C00 C01 0 1 1 1 1 2
E 9 0 0 200 C02 C03 2 3 1 1 1 2
C 3221C657 2 2 5 3 0
E 300 300 205 205 C00 C01 0 1 1 1 1 2
C 32233657 2 2 0 6 0
E 600 600 206 206 C00 C01 0 1 1 1 1 2
C C6208757 2 0 0 1 0
E 100 101 200 201 E00 E01 0 1 1 1 1 1
C C6208757 2 1 0 1 0
E 100 101 200 201 E00 E01 0 1 1 1 1 2
C 00208457 4 2 0 1 0
E 100 101 200 201 800 801 0 1 0 1 1 2
E 102 103 202 203 802 803 2 3 1 1 1 2
F 02208457 8 2 0
I 00208433
I 3A208457

// ==== vlog.f ====
+incdir+testbench
logic/vdec_pkg.sv
logic/vinstr_decoder.sv
logic/element_sequencer.sv
logic/offset_gen.sv
logic/vector_regfile.sv
logic/decode_execute_reg.sv
logic/vector_decode_top.sv
testbench/vector_decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run; pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module vector_decode_tb -f vlog.f -o vdec_sim \
  && ./obj_dir/vdec_sim | tee /dev/stderr | grep -q "All checks passed" \
  && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }
